// File: hw/bbc_mem_pkg.sv
`default_nettype none

package bbc_mem_pkg;

	localparam int sdram_addr_w = 25;
	localparam int cpu_addr_w = 16;
	localparam int load_index_w = 8;

	// download targets in sdram
	localparam logic [sdram_addr_w-1:0] os_load_base = 25'h80000;
	localparam logic [sdram_addr_w-1:0] rom_load_base = 25'h68000;
	localparam logic [load_index_w-1:0] cmos_index = 8'hff;

	// region bases of the sdram map, banks are 16k each
	localparam int bank_shift = 14;
	localparam logic [sdram_addr_w-1:0] modelb_rom_base = 25'h90000;
	localparam logic [sdram_addr_w-1:0] master_rom_base = 25'hA0000;
	localparam logic [sdram_addr_w-1:0] swram_base = 25'h40000;
	localparam logic [2:0] filing_ram_code = 3'b101;

	// hold-off after a model or rom map change
	localparam int remap_hold_cycles = 4095;
	localparam int remap_cnt_w = 12;

	typedef struct packed {
		logic [sdram_addr_w-1:0] addr;
		logic [7:0]              data;
		logic [load_index_w-1:0] index;
	} load_req_t;

	typedef struct packed {
		logic [cpu_addr_w-1:0] adr;
		logic [7:0]            romsel;
		logic [7:0]            wdata;
		logic                  we;
		logic                  acc_y;
		logic                  shadow_ram;
		logic                  shadow_vid;
		logic                  phi0;
	} cpu_access_t;

	typedef struct packed {
		logic [sdram_addr_w-1:0] adr;
		logic                    we;
		logic [7:0]              wdata;
	} sdram_cmd_t;

	typedef struct packed {
		logic model;
		logic rommap;
	} machine_cfg_t;

endpackage

`default_nettype wire

// File: hw/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  wire logic                   clk_48m,
	input  wire logic                   reset,
	input  wire logic                   download_active,
	input  wire bbc_mem_pkg::load_req_t load_req,
	input  wire logic                   load_req_valid,
	input  wire logic                   mem_sync,
	output logic                        load_ack,
	output bbc_mem_pkg::sdram_cmd_t     loader_cmd
);
	import bbc_mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_pending,
		st_acked
	} state_t;

	state_t                  state;
	logic                    issued;
	logic [sdram_addr_w-1:0] load_base;
	logic [sdram_addr_w-1:0] wr_adr;
	logic [7:0]              wr_data;

	// index 0 is the os image, all other roms share one window
	assign load_base = (load_req.index == '0) ? os_load_base : rom_load_base;

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			state <= st_idle;
			load_ack <= 1'b0;
			issued <= 1'b0;
		end else begin
			// write stays up for one full slot
			if (mem_sync)
				issued <= (state == st_pending);
			case (state)
				st_idle: begin
					if (load_req_valid && download_active) begin
						if (load_req.index == cmos_index) begin
							// no cmos here, just acknowledge
							state <= st_acked;
							load_ack <= 1'b1;
						end else begin
							state <= st_pending;
						end
					end
				end
				st_pending: begin
					if (mem_sync) begin
						state <= st_acked;
						load_ack <= 1'b1;
					end
				end
				st_acked: begin
					if (!load_req_valid) begin
						state <= st_idle;
						load_ack <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// beat captured as req is seen
	always_ff @(posedge clk_48m) begin
		if (state == st_idle && load_req_valid) begin
			wr_adr <= load_req.addr + load_base;
			wr_data <= load_req.data;
		end
	end

	assign loader_cmd = '{
		adr: wr_adr,
		we: issued || (state == st_pending && mem_sync),
		wdata: wr_data
	};

	// io controller must not move the beat before it is acknowledged
	a_req_stable: assert property (@(posedge clk_48m) disable iff (reset)
		(load_req_valid && !load_ack) ##1 (load_req_valid && !load_ack) |-> $stable(load_req));

endmodule

`default_nettype wire

// File: hw/cpu_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_addr_map (
	input  wire logic                        clk_48m,
	input  wire logic                        reset,
	input  wire logic                        mem_sync,
	input  wire bbc_mem_pkg::cpu_access_t    cpu_access,
	input  wire bbc_mem_pkg::machine_cfg_t   cfg,
	output bbc_mem_pkg::sdram_cmd_t          cpu_cmd
);
	import bbc_mem_pkg::*;

	logic                    cpu_ram;
	logic                    mos_rom;
	logic                    sideways;
	logic                    mos_ram;
	logic                    filing_ram;
	logic                    sideways_ram;
	logic                    sideways_rom;
	logic [sdram_addr_w-1:0] map_adr;
	logic                    map_we;
	logic [sdram_addr_w-1:0] cmd_adr;
	logic                    cmd_we;
	logic [7:0]              cmd_wdata;

	function automatic logic [sdram_addr_w-1:0] bank_addr(
		input logic [sdram_addr_w-1:0] base,
		input logic [3:0]              bank,
		input logic [bank_shift-1:0]   offset
	);
		return base + (sdram_addr_w'(bank) << bank_shift) + sdram_addr_w'(offset);
	endfunction

	assign cpu_ram = !cpu_access.adr[15];
	assign mos_rom = (cpu_access.adr[15:14] == 2'b11);
	assign sideways = (cpu_access.adr[15:14] == 2'b10);
	// master private ram at 8000-8fff
	assign mos_ram = sideways && (cpu_access.adr[13:12] == 2'b00) && cpu_access.romsel[7];
	assign filing_ram = (cpu_access.adr[15:13] == 3'b110) && cpu_access.acc_y;
	// banks 4 to 7 are ram
	assign sideways_ram = sideways && (cpu_access.romsel[3:2] == 2'b01);

	// model b maps its four roms high or low depending on rommap
	assign sideways_rom = sideways && (cfg.model ?
		(cpu_access.romsel[3:2] == 2'b00 || cpu_access.romsel[3]) :
		(cpu_access.romsel[3:2] == (cfg.rommap ? 2'b00 : 2'b11)));

	always_comb begin
		if (!cpu_access.phi0)
			map_adr = sdram_addr_w'({cpu_access.shadow_vid, cpu_access.adr});
		else if (cpu_ram || mos_ram)
			map_adr = sdram_addr_w'({cpu_access.shadow_ram, cpu_access.adr});
		else if (filing_ram)
			map_adr = sdram_addr_w'({filing_ram_code, cpu_access.adr[12:0]});
		else if (mos_rom)
			map_adr = bank_addr(os_load_base, {3'b000, cfg.model}, cpu_access.adr[13:0]);
		else if (sideways_rom && !cfg.model)
			map_adr = bank_addr(modelb_rom_base, {2'b00, cpu_access.romsel[1:0]},
				cpu_access.adr[13:0]);
		else if (sideways_rom)
			map_adr = bank_addr(master_rom_base, cpu_access.romsel[3:0], cpu_access.adr[13:0]);
		else
			map_adr = bank_addr(swram_base, cpu_access.romsel[3:0], cpu_access.adr[13:0]);
	end

	// roms are write protected, video never writes
	assign map_we = cpu_access.we && cpu_access.phi0 &&
		(cpu_ram || sideways_ram || mos_ram || filing_ram);

	always_ff @(posedge clk_48m) begin
		if (reset)
			cmd_we <= 1'b0;
		else if (mem_sync)
			cmd_we <= map_we;
	end

	always_ff @(posedge clk_48m) begin
		if (mem_sync) begin
			cmd_adr <= map_adr;
			cmd_wdata <= cpu_access.wdata;
		end
	end

	assign cpu_cmd = '{adr: cmd_adr, we: cmd_we, wdata: cmd_wdata};

	// cpu writes never land in the rom images
	a_rom_protect: assert property (@(posedge clk_48m) disable iff (reset)
		cpu_cmd.we |-> cpu_cmd.adr < rom_load_base);

endmodule

`default_nettype wire

// File: hw/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int autoboot_cycles = 32000000
) (
	input  wire logic                      clk_48m,
	input  wire logic                      reset,
	input  wire logic                      mem_sync,
	input  wire logic                      op_reset,
	input  wire logic                      download_active,
	input  wire bbc_mem_pkg::machine_cfg_t cfg,
	input  wire logic                      autoboot_en,
	output logic                           core_reset,
	output logic                           autoboot_shift
);
	import bbc_mem_pkg::*;

	machine_cfg_t                         cfg_q;
	logic [remap_cnt_w-1:0]               remap_cnt;
	logic [$clog2(autoboot_cycles+1)-1:0] boot_cnt;
	logic                                 reset_req;

	// model or rom map change restarts the machine
	always_ff @(posedge clk_48m) begin
		cfg_q <= cfg;
		if (reset)
			remap_cnt <= '0;
		else if (cfg != cfg_q)
			remap_cnt <= remap_cnt_w'(remap_hold_cycles);
		else if (remap_cnt != '0)
			remap_cnt <= remap_cnt - 1'b1;
	end

	assign reset_req = op_reset || download_active || (remap_cnt != '0);

	// only switch on a slot boundary so the memory cycle is never cut
	always_ff @(posedge clk_48m) begin
		if (reset)
			core_reset <= 1'b1;
		else if (mem_sync)
			core_reset <= reset_req;
	end

	// shift held down a while after reset for autoboot
	always_ff @(posedge clk_48m) begin
		if (reset || core_reset)
			boot_cnt <= $bits(boot_cnt)'(autoboot_cycles);
		else if (boot_cnt != '0)
			boot_cnt <= boot_cnt - 1'b1;
	end

	assign autoboot_shift = autoboot_en && (boot_cnt != '0);

	a_reset_on_slot: assert property (@(posedge clk_48m) disable iff (reset)
		!$stable(core_reset) |-> $past(mem_sync));

endmodule

`default_nettype wire

// File: hw/sdram_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_mux (
	input  wire logic                    clk_48m,
	input  wire logic                    reset,
	input  wire logic                    download_active,
	input  wire bbc_mem_pkg::sdram_cmd_t loader_cmd,
	input  wire bbc_mem_pkg::sdram_cmd_t cpu_cmd,
	output bbc_mem_pkg::sdram_cmd_t      sdram
);
	import bbc_mem_pkg::*;

	logic [sdram_addr_w-1:0] out_adr;
	logic                    out_we;
	logic [7:0]              out_wdata;

	// loader owns the port for the whole download
	always_ff @(posedge clk_48m) begin
		if (reset)
			out_we <= 1'b0;
		else
			out_we <= download_active ? loader_cmd.we : cpu_cmd.we;
	end

	always_ff @(posedge clk_48m) begin
		if (download_active) begin
			out_adr <= loader_cmd.adr;
			out_wdata <= loader_cmd.wdata;
		end else begin
			out_adr <= cpu_cmd.adr;
			out_wdata <= cpu_cmd.wdata;
		end
	end

	assign sdram = '{adr: out_adr, we: out_we, wdata: out_wdata};

endmodule

`default_nettype wire

// File: hw/bbc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module bbc_mem_top #(
	parameter int autoboot_cycles = 32000000
) (
	input  wire logic                      clk_48m,
	input  wire logic                      reset,
	input  wire logic                      mem_sync,
	input  wire bbc_mem_pkg::cpu_access_t  cpu_access,
	input  wire bbc_mem_pkg::machine_cfg_t cfg,
	input  wire logic                      op_reset,
	input  wire logic                      autoboot_en,
	input  wire logic                      download_active,
	input  wire bbc_mem_pkg::load_req_t    load_req,
	input  wire logic                      load_req_valid,
	output logic                           load_ack,
	output bbc_mem_pkg::sdram_cmd_t        sdram,
	output logic                           core_reset,
	output logic                           autoboot_shift
);
	import bbc_mem_pkg::*;

	sdram_cmd_t loader_cmd;
	sdram_cmd_t cpu_cmd;

	// rom download from the io controller
	rom_loader i_rom_loader (
		.clk_48m         (clk_48m),
		.reset           (reset),
		.download_active (download_active),
		.load_req        (load_req),
		.load_req_valid  (load_req_valid),
		.mem_sync        (mem_sync),
		.load_ack        (load_ack),
		.loader_cmd      (loader_cmd)
	);

	cpu_addr_map i_cpu_addr_map (
		.clk_48m    (clk_48m),
		.reset      (reset),
		.mem_sync   (mem_sync),
		.cpu_access (cpu_access),
		.cfg        (cfg),
		.cpu_cmd    (cpu_cmd)
	);

	reset_sequencer #(
		.autoboot_cycles (autoboot_cycles)
	) i_reset_sequencer (
		.clk_48m         (clk_48m),
		.reset           (reset),
		.mem_sync        (mem_sync),
		.op_reset        (op_reset),
		.download_active (download_active),
		.cfg             (cfg),
		.autoboot_en     (autoboot_en),
		.core_reset      (core_reset),
		.autoboot_shift  (autoboot_shift)
	);

	// one command per slot towards the sdram controller
	sdram_port_mux i_sdram_port_mux (
		.clk_48m         (clk_48m),
		.reset           (reset),
		.download_active (download_active),
		.loader_cmd      (loader_cmd),
		.cpu_cmd         (cpu_cmd),
		.sdram           (sdram)
	);

endmodule

`default_nettype wire

// File: test/bbc_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bbc_mem_tb;
	import bbc_mem_pkg::*;

	localparam int autoboot_len = 200;
	localparam int slot_timeout = 20;

	logic         clk_48m = 1'b0;
	logic         reset;
	logic         mem_sync = 1'b0;
	cpu_access_t  cpu_access;
	machine_cfg_t cfg;
	logic         op_reset;
	logic         autoboot_en;
	logic         download_active;
	load_req_t    load_req;
	logic         load_req_valid;
	logic         load_ack;
	sdram_cmd_t   sdram;
	logic         core_reset;
	logic         autoboot_shift;

	logic [15:0]  lfsr = 16'd29770;
	logic [15:0]  sync_lfsr = 16'd29770;
	logic [2:0]   sync_cnt = 3'd0;
	// values seen by the last rising edge
	logic         sync_edge = 1'b0;
	logic         reset_edge = 1'b1;
	logic         dl_edge = 1'b0;
	logic         core_reset_seen = 1'b1;
	int           value_errors = 0;
	int           protocol_errors = 0;
	int           timeouts = 0;

	bbc_mem_top #(
		.autoboot_cycles (autoboot_len)
	) i_bbc_mem_top (
		.clk_48m         (clk_48m),
		.reset           (reset),
		.mem_sync        (mem_sync),
		.cpu_access      (cpu_access),
		.cfg             (cfg),
		.op_reset        (op_reset),
		.autoboot_en     (autoboot_en),
		.download_active (download_active),
		.load_req        (load_req),
		.load_req_valid  (load_req_valid),
		.load_ack        (load_ack),
		.sdram           (sdram),
		.core_reset      (core_reset),
		.autoboot_shift  (autoboot_shift)
	);

	always #5 clk_48m = ~clk_48m;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(inout logic [15:0] state, input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
		end
		return v;
	endfunction

	function automatic cpu_access_t random_access();
		cpu_access_t a;
		a.adr = 16'(rand_bits(lfsr, 16));
		a.romsel = 8'(rand_bits(lfsr, 8));
		a.wdata = 8'(rand_bits(lfsr, 8));
		a.we = rand_bits(lfsr, 1) != 0;
		a.acc_y = rand_bits(lfsr, 1) != 0;
		a.shadow_ram = rand_bits(lfsr, 1) != 0;
		a.shadow_vid = rand_bits(lfsr, 1) != 0;
		a.phi0 = rand_bits(lfsr, 1) != 0;
		return a;
	endfunction

	// slot pulse every 3 to 6 cycles
	always @(posedge clk_48m) begin
		if (sync_cnt == 3'd0) begin
			mem_sync <= 1'b1;
			sync_cnt <= 3'd2 + 3'(rand_bits(sync_lfsr, 2));
		end else begin
			mem_sync <= 1'b0;
			sync_cnt <= sync_cnt - 3'd1;
		end
	end

	always @(posedge clk_48m) begin
		sync_edge <= mem_sync;
		reset_edge <= reset;
		dl_edge <= download_active;
	end

	// expected sdram command for one cpu or video access
	function automatic sdram_cmd_t expected_cpu_cmd(input cpu_access_t a, input machine_cfg_t c);
		sdram_cmd_t  r;
		logic        low_ram;
		logic        os_rom;
		logic        sw;
		logic        os_ram;
		logic        fs_ram;
		logic        sw_ram;
		logic        sw_rom;
		logic [24:0] off;
		low_ram = (a.adr < 16'h8000);
		os_rom = (a.adr >= 16'hC000);
		sw = !low_ram && !os_rom;
		os_ram = sw && (a.adr < 16'h9000) && a.romsel[7];
		fs_ram = (a.adr >= 16'hC000) && (a.adr < 16'hE000) && a.acc_y;
		sw_ram = sw && (a.romsel[3:0] >= 4'd4) && (a.romsel[3:0] < 4'd8);
		if (c.model)
			sw_rom = (a.romsel[3:0] < 4'd4) || (a.romsel[3:0] >= 4'd8);
		else if (c.rommap)
			sw_rom = (a.romsel[3:0] < 4'd4);
		else
			sw_rom = (a.romsel[3:0] >= 4'd12);
		off = {11'd0, a.adr[13:0]};
		if (!a.phi0)
			r.adr = {8'd0, a.shadow_vid, a.adr};
		else if (low_ram || os_ram)
			r.adr = {8'd0, a.shadow_ram, a.adr};
		else if (fs_ram)
			r.adr = {9'd0, 3'b101, a.adr[12:0]};
		else if (os_rom)
			r.adr = 25'h80000 + (c.model ? 25'h4000 : 25'h0) + off;
		else if (sw_rom && !c.model)
			r.adr = 25'h90000 + a.romsel[1:0] * 25'h4000 + off;
		else if (sw_rom)
			r.adr = 25'hA0000 + a.romsel[3:0] * 25'h4000 + off;
		else
			r.adr = 25'h40000 + a.romsel[3:0] * 25'h4000 + off;
		r.we = a.we && a.phi0 && (low_ram || sw_ram || os_ram || fs_ram);
		r.wdata = a.wdata;
		return r;
	endfunction

	task automatic check_cmd(input string what, input sdram_cmd_t got, input sdram_cmd_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: sdram (%s) expected adr=%h we=%h wdata=%h, got adr=%h we=%h wdata=%h",
				what, exp.adr, exp.we, exp.wdata, got.adr, got.we, got.wdata);
		end
	endtask

	task automatic check_ack(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: load_ack (%s) expected %h got %h", what, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s expected %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	always @(negedge clk_48m) begin
		if (!reset_edge && core_reset !== core_reset_seen && !sync_edge) begin
			protocol_errors++;
			$display("core_reset changed at %0t outside a memory slot", $time);
		end
		core_reset_seen = core_reset;
		if (!autoboot_en)
			check_flag("autoboot_shift", autoboot_shift, 1'b0);
		if (dl_edge && sdram.we && sdram.adr < rom_load_base) begin
			protocol_errors++;
			$display("cpu write to %h reached sdram during a download", sdram.adr);
		end
	end

	// returns at the rising edge that samples a slot
	task automatic wait_slot();
		int n;
		n = 0;
		do begin
			@(posedge clk_48m);
			n++;
		end while (!mem_sync && n < slot_timeout);
		if (!mem_sync) begin
			timeouts++;
			$display("no memory slot within %0d cycles", slot_timeout);
		end
	endtask

	task automatic wait_core_reset(input logic level, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk_48m);
			cycles++;
		end while (core_reset !== level && cycles < limit);
		if (core_reset !== level) begin
			timeouts++;
			$display("core_reset did not reach %0b within %0d cycles", level, limit);
		end
	endtask

	// one four-phase download beat
	task automatic load_beat(input logic [7:0] index);
		load_req_t  beat;
		sdram_cmd_t exp;
		int         n;
		beat.addr = 25'(rand_bits(lfsr, 16));
		beat.data = 8'(rand_bits(lfsr, 8));
		beat.index = index;
		exp.adr = beat.addr + ((index == 8'h00) ? os_load_base : rom_load_base);
		exp.we = 1'b1;
		exp.wdata = beat.data;
		n = 0;
		while (sdram.we && n < slot_timeout) begin
			@(negedge clk_48m);
			n++;
		end
		if (sdram.we) begin
			timeouts++;
			$display("sdram write still active before beat with index %h", index);
		end
		check_ack("before req", load_ack, 1'b0);
		@(posedge clk_48m);
		load_req <= beat;
		load_req_valid <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_48m);
			n++;
			if (!load_ack && sdram.we) begin
				protocol_errors++;
				$display("sdram write before load_ack for index %h", index);
			end
		end while (!load_ack && n < slot_timeout);
		if (!load_ack) begin
			timeouts++;
			$display("no load_ack for index %h within %0d cycles", index, slot_timeout);
		end else if (index == cmos_index) begin
			check_flag("sdram.we", sdram.we, 1'b0);
		end else begin
			check_cmd("rom write", sdram, exp);
			if (!sync_edge) begin
				protocol_errors++;
				$display("rom write for index %h not aligned to a slot", index);
			end
		end
		@(posedge clk_48m);
		load_req_valid <= 1'b0;
		@(negedge clk_48m);
		check_ack("held until req low is seen", load_ack, 1'b1);
		n = 0;
		while (load_ack && n < slot_timeout) begin
			@(negedge clk_48m);
			n++;
			if (index == cmos_index)
				check_flag("sdram.we", sdram.we, 1'b0);
		end
		if (load_ack) begin
			timeouts++;
			$display("load_ack did not drop for index %h", index);
		end
	endtask

	initial begin
		cpu_access_t  acc;
		machine_cfg_t new_cfg;
		sdram_cmd_t   exp;
		int           cycles;
		int           hold;
		int           i;
		reset = 1'b1;
		cpu_access = '0;
		cfg = '0;
		op_reset = 1'b0;
		autoboot_en = 1'b0;
		download_active = 1'b0;
		load_req = '0;
		load_req_valid = 1'b0;
		repeat (10) @(posedge clk_48m);
		reset <= 1'b0;
		@(negedge clk_48m);
		check_flag("core_reset", core_reset, 1'b1);
		check_flag("sdram.we", sdram.we, 1'b0);
		check_ack("after reset", load_ack, 1'b0);
		wait_core_reset(1'b0, slot_timeout, cycles);

		// random cpu and video accesses
		@(posedge clk_48m);
		for (i = 0; i < 300; i++) begin
			acc = random_access();
			new_cfg = machine_cfg_t'(2'(rand_bits(lfsr, 2)));
			cpu_access <= acc;
			cfg <= new_cfg;
			wait_slot();
			exp = expected_cpu_cmd(acc, new_cfg);
			@(posedge clk_48m);
			@(negedge clk_48m);
			check_cmd("cpu access", sdram, exp);
			@(posedge clk_48m);
		end

		// download while the cpu keeps writing to ram
		acc = random_access();
		acc.adr[15] = 1'b0;
		acc.we = 1'b1;
		acc.phi0 = 1'b1;
		@(posedge clk_48m);
		cpu_access <= acc;
		download_active <= 1'b1;
		for (i = 0; i < 24; i++) begin
			case (i % 3)
				0: load_beat(8'h00);
				1: load_beat(8'h05);
				default: load_beat(cmos_index);
			endcase
		end
		@(posedge clk_48m);
		download_active <= 1'b0;
		cpu_access <= '0;
		wait_core_reset(1'b0, remap_hold_cycles + 100, cycles);

		// model change with autoboot
		@(posedge clk_48m);
		autoboot_en <= 1'b1;
		cfg.model <= !cfg.model;
		wait_core_reset(1'b1, slot_timeout, cycles);
		if (cycles > 8) begin
			protocol_errors++;
			$display("core_reset rose %0d cycles after the model change", cycles);
		end
		wait_core_reset(1'b0, remap_hold_cycles + 20, hold);
		if (cycles + hold < remap_hold_cycles || cycles + hold > remap_hold_cycles + 12) begin
			protocol_errors++;
			$display("core_reset held %0d cycles after the model change", cycles + hold);
		end
		cycles = 0;
		while (autoboot_shift && cycles < autoboot_len + 20) begin
			cycles++;
			@(negedge clk_48m);
		end
		if (cycles != autoboot_len) begin
			protocol_errors++;
			$display("autoboot_shift high for %0d cycles instead of %0d", cycles, autoboot_len);
		end

		// rom map change, shift must stay low
		@(posedge clk_48m);
		autoboot_en <= 1'b0;
		cfg.rommap <= !cfg.rommap;
		wait_core_reset(1'b1, slot_timeout, cycles);
		wait_core_reset(1'b0, remap_hold_cycles + 20, hold);
		repeat (autoboot_len + 20) @(negedge clk_48m);

		$display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
			value_errors, protocol_errors, timeouts);
		if (value_errors + protocol_errors + timeouts == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hw/bbc_mem_pkg.sv
hw/rom_loader.sv
hw/cpu_addr_map.sv
hw/reset_sequencer.sv
hw/sdram_port_mux.sv
hw/bbc_mem_top.sv
test/bbc_mem_tb.sv
